//--- vlog.f
src/tty_pkg.sv
src/tty_if.sv
src/iot_decode.sv
src/tty_tx.sv
src/tty_rx.sv
src/tty_console.sv
test/tb_tty_console.sv

//--- test/tb_tty_console.sv
`timescale 1ns/10ps

module tb_tty_console
  import tty_pkg::*;
();

  localparam int CPB   = 16;
  localparam int LIMIT = 40 * 12 * CPB;

  logic  clk100;
  logic  rst;
  logic  iot_valid;
  word_t iot_word;
  word_t ac_in;
  logic  skip;
  logic  ac_clear;
  word_t ac_out;
  logic  irq;
  logic  txd;
  logic  rxd;

  // flags and keyboard buffer as the IOT table leaves them
  logic  kbd_flag;
  logic  prt_flag;
  char_t kbd_buf;

  logic [31:0] rng;
  logic        seen_skip;
  char_t       c0;
  char_t       c1;
  char_t       got;
  int          polls;
  int          cycles = 0;

  tty_console #(.CLKS_PER_BIT(CPB), .STOP_BITS(2)) UUT (.*);

  initial begin
    clk100 = 1'b0;
    forever #50 clk100 = ~clk100;
  end

  always @(posedge clk100) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout, the run was still going after %0d cycles", cycles);
      abort_run();
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // expected skip, ac_clear and ac_out of one word from the IOT table
  function automatic logic [WORD_W+1:0] expect_iot(input word_t w, input logic kf,
                                                    input logic pf, input char_t kb);
    logic  s;
    logic  c;
    word_t d;
    s = 1'b0;
    c = 1'b0;
    d = '0;
    case (w)
      12'o6031: s = kf;
      12'o6032: c = 1'b1;
      12'o6034: d = word_t'(kb);
      12'o6036: begin
        c = 1'b1;
        d = word_t'(kb);
      end
      12'o6041: s = pf;
      default: ;
    endcase
    return {s, c, d};
  endfunction

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got_v, input logic exp_v);
    if (got_v !== exp_v) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got_v, exp_v);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input word_t got_v, input word_t exp_v);
    if (got_v !== exp_v) begin
      $display("[FAIL] %0t %s got %o expected %o", $time, name, got_v, exp_v);
      abort_run();
    end
  endtask

  task automatic check_char(input string name, input char_t got_v, input char_t exp_v);
    if (got_v !== exp_v) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got_v, exp_v);
      abort_run();
    end
  endtask

  // every IOT cycle is checked where the combinational answer has settled
  always @(negedge clk100) begin : compare
    logic [WORD_W+1:0] exp_out;
    if (iot_valid) begin
      exp_out = expect_iot(iot_word, kbd_flag, prt_flag, kbd_buf);
      check_bit("skip", skip, exp_out[WORD_W+1]);
      check_bit("ac_clear", ac_clear, exp_out[WORD_W]);
      check_word("ac_out", ac_out, exp_out[WORD_W-1:0]);
    end
  end

  // puts a word on the bus and leaves it there for the next one
  task automatic iot_hold(input word_t w, input word_t ac);
    @(posedge clk100);
    iot_valid <= 1'b1;
    iot_word  <= w;
    ac_in     <= ac;
  endtask

  task automatic iot(input word_t w, input word_t ac);
    iot_hold(w, ac);
    @(negedge clk100);
    seen_skip = skip;
    @(posedge clk100);
    iot_valid <= 1'b0;
  endtask

  // keyboard line model with start bit, eight bits LSB first and one stop bit
  task automatic send_rx(input char_t c);
    @(posedge clk100);
    rxd <= 1'b0;
    for (int i = 0; i <= CHAR_W; i++) begin
      repeat (CPB) @(posedge clk100);
      rxd <= (i == CHAR_W) ? 1'b1 : c[i];
    end
    repeat (CPB) @(posedge clk100);
  endtask

  // printer line model sampling near the middle of each bit
  task automatic capture_tx(output char_t c);
    @(negedge txd);
    repeat (CPB / 2) @(negedge clk100);
    check_bit("txd start", txd, 1'b0);
    for (int i = 0; i < CHAR_W; i++) begin
      repeat (CPB) @(negedge clk100);
      c[i] = txd;
    end
    repeat (CPB) @(negedge clk100);
    check_bit("txd stop", txd, 1'b1);
  endtask

  // irq trails flags and enable by one register stage
  task automatic check_irq(input logic exp_v);
    repeat (2) @(negedge clk100);
    check_bit("irq", irq, exp_v);
  endtask

  initial begin
    rst       = 1'b1;
    iot_valid = 1'b0;
    iot_word  = '0;
    ac_in     = '0;
    rxd       = 1'b1;
    kbd_flag  = 1'b0;
    prt_flag  = 1'b0;
    kbd_buf   = '0;
    rng       = 32'd68210;
    repeat (8) @(posedge clk100);
    rst <= 1'b0;

    check_irq(1'b0);
    check_bit("txd", txd, 1'b1);
    iot(12'o6041, '0);
    iot(12'o6031, '0);
    iot(12'o6034, '0);

    // printer ready before the first load
    iot(12'o6040, '0);
    prt_flag = 1'b1;
    iot(12'o6041, '0);

    // TLS then TPC back to back so the second load finds a character pending
    rng = xorshift(rng);
    c0  = rng[7:0];
    rng = xorshift(rng);
    c1  = rng[7:0];
    fork
      capture_tx(got);
      begin
        iot_hold(12'o6046, word_t'(c0));
        prt_flag = 1'b0;
        iot(12'o6044, word_t'(c1));
        iot(12'o6041, '0);
      end
    join
    check_char("txd frame", got, c0);
    prt_flag = 1'b1;
    repeat (24 * CPB) begin
      @(negedge clk100);
      check_bit("txd idle", txd, 1'b1);
    end
    iot(12'o6041, '0);
    iot(12'o6042, '0);
    prt_flag = 1'b0;
    iot(12'o6041, '0);
    iot(12'o6040, '0);
    prt_flag = 1'b1;
    iot(12'o6041, '0);

    // receive and read with KRB
    rng = xorshift(rng);
    c0  = rng[7:0];
    send_rx(c0);
    kbd_flag  = 1'b1;
    kbd_buf   = c0;
    polls     = 0;
    seen_skip = 1'b0;
    while (!seen_skip && (polls < 8)) begin
      iot(12'o6031, '0);
      polls++;
    end
    if (!seen_skip) begin
      $display("keyboard flag was never seen after a frame on rxd");
      abort_run();
    end
    iot(12'o6036, '0);
    kbd_flag = 1'b0;
    iot(12'o6031, '0);

    // keyboard interrupt and then disable with the printer flag set
    iot(12'o6042, '0);
    prt_flag = 1'b0;
    iot(12'o6035, 12'o0001);
    check_irq(1'b0);
    rng = xorshift(rng);
    c0  = rng[7:0];
    send_rx(c0);
    kbd_flag = 1'b1;
    kbd_buf  = c0;
    check_irq(1'b1);
    iot(12'o6032, '0);
    kbd_flag = 1'b0;
    check_irq(1'b0);
    iot(12'o6035, '0);
    iot(12'o6040, '0);
    prt_flag = 1'b1;
    check_irq(1'b0);
    iot(12'o6041, '0);

    $display("Regression passed");
    $finish;
  end

endmodule

//--- src/tty_console.sv
`timescale 1ns/10ps

module tty_console
  import tty_pkg::*;
#(
  parameter int CLKS_PER_BIT = 868,
  parameter int STOP_BITS    = 2
) (
  input  logic  clk100,
  input  logic  rst,
  input  logic  iot_valid,
  input  word_t iot_word,
  input  word_t ac_in,
  output logic  skip,
  output logic  ac_clear,
  output word_t ac_out,
  output logic  irq,
  output logic  txd,
  input  logic  rxd
);

  // device 04 and device 03 buses
  tty_if prt_bus ();
  tty_if kbd_bus ();

  iot_decode u_decode (
    .clk100    (clk100),
    .rst       (rst),
    .iot_valid (iot_valid),
    .iot_word  (iot_word),
    .ac_in     (ac_in),
    .skip      (skip),
    .ac_clear  (ac_clear),
    .ac_out    (ac_out),
    .irq       (irq),
    .prt       (prt_bus.ctrl),
    .kbd       (kbd_bus.ctrl)
  );

  tty_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .STOP_BITS    (STOP_BITS)
  ) u_tx (
    .clk100 (clk100),
    .rst    (rst),
    .bus    (prt_bus.unit),
    .txd    (txd)
  );

  tty_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk100 (clk100),
    .rst    (rst),
    .bus    (kbd_bus.unit),
    .rxd    (rxd)
  );

endmodule

//--- src/tty_rx.sv
`timescale 1ns/10ps

module tty_rx
  import tty_pkg::*;
#(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic clk100,
  input  logic rst,
  tty_if.unit  bus,
  input  logic rxd
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  // half a bit, less the three cycles spent in sync and edge detect
  localparam int HALF = CLKS_PER_BIT / 2;
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'((HALF > 3) ? HALF - 3 : 0);

  localparam logic [1:0] R_IDLE  = 2'd0;
  localparam logic [1:0] R_START = 2'd1;
  localparam logic [1:0] R_DATA  = 2'd2;
  localparam logic [1:0] R_STOP  = 2'd3;

  logic             rx_s1;
  logic             rx_s2;
  logic             rx_prev;
  logic             fall;
  logic             bit_end;
  logic [1:0]       state;
  logic [CNT_W-1:0] baud_cnt;
  logic [2:0]       bit_idx;
  char_t            shreg;

  assign fall    = rx_prev && !rx_s2;
  assign bit_end = (baud_cnt == '0);

  // two flops against metastability, a third for the edge
  always_ff @(posedge clk100) begin
    if (rst) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rxd;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge clk100) begin
    if (rst) begin
      state      <= R_IDLE;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      bus.flag   <= 1'b0;
      bus.buffer <= '0;
    end else begin
      if (bus.clear_flag)
        bus.flag <= 1'b0;
      if (!bit_end)
        baud_cnt <= baud_cnt - 1'b1;

      case (state)
        R_IDLE: begin
          if (fall) begin
            state    <= R_START;
            baud_cnt <= HALF_LAST;
          end
        end
        R_START: begin
          if (bit_end) begin
            // line back high at mid start is a glitch
            state    <= rx_s2 ? R_IDLE : R_DATA;
            baud_cnt <= BIT_LAST;
            bit_idx  <= '0;
          end
        end
        R_DATA: begin
          if (bit_end) begin
            baud_cnt <= BIT_LAST;
            bit_idx  <= bit_idx + 3'd1;
            if (bit_idx == 3'd7)
              state <= R_STOP;
          end
        end
        default: begin
          // stop bit sampled at its center, low means framing error
          if (bit_end) begin
            state <= R_IDLE;
            if (rx_s2) begin
              bus.buffer <= shreg;
              bus.flag   <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  // LSB arrives first, shift in from the top
  always_ff @(posedge clk100) begin
    if ((state == R_DATA) && bit_end)
      shreg <= {rx_s2, shreg[CHAR_W-1:1]};
  end

endmodule

//--- src/tty_tx.sv
`timescale 1ns/10ps

module tty_tx
  import tty_pkg::*;
#(
  parameter int CLKS_PER_BIT = 868,
  parameter int STOP_BITS    = 2
) (
  input  logic clk100,
  input  logic rst,
  tty_if.unit  bus,
  output logic txd
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  // data states must stay in sequence, the FSM steps by one
  localparam logic [3:0] S_IDLE  = 4'd0;
  localparam logic [3:0] S_START = 4'd1;
  localparam logic [3:0] S_BIT0  = 4'd2;
  localparam logic [3:0] S_BIT7  = 4'd9;
  localparam logic [3:0] S_STOP1 = 4'd10;
  localparam logic [3:0] S_STOP2 = 4'd11;

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       state;
  logic [2:0]       bit_sel;
  char_t            tto;
  logic             pending;
  logic             load_ok;
  logic             bit_end;
  logic             in_stop;

  assign bit_end = (baud_cnt == '0);
  assign bit_sel = 3'(state - S_BIT0);
  assign in_stop = (state == S_STOP1) || (state == S_STOP2);

  // one character may wait, a second load before it starts is dropped
  assign load_ok = bus.load && !pending && ((state == S_IDLE) || in_stop);

  assign bus.buffer = tto;

  always_ff @(posedge clk100) begin
    if (rst) begin
      state    <= S_IDLE;
      baud_cnt <= '0;
      pending  <= 1'b0;
      bus.flag <= 1'b0;
      tto      <= 8'o040;
      txd      <= 1'b1;
    end else begin
      // set has the last word when both arrive
      if (bus.clear_flag || load_ok)
        bus.flag <= 1'b0;
      if (bus.set_flag || ((state == S_BIT7) && bit_end))
        bus.flag <= 1'b1;

      if (load_ok) begin
        tto     <= bus.data;
        pending <= 1'b1;
      end

      if (state == S_IDLE) begin
        // idle looks at pending every cycle, no baud wait
        if (pending) begin
          state    <= S_START;
          baud_cnt <= BIT_LAST;
          pending  <= 1'b0;
        end
      end else if (bit_end) begin
        baud_cnt <= BIT_LAST;
        case (state)
          S_STOP1: state <= (STOP_BITS == 2) ? S_STOP2 : S_IDLE;
          S_STOP2: state <= S_IDLE;
          default: state <= (state < S_STOP1) ? state + 4'd1 : S_IDLE;
        endcase
      end else begin
        baud_cnt <= baud_cnt - 1'b1;
      end

      // line follows the state one cycle later
      if (state == S_START)
        txd <= 1'b0;
      else if ((state >= S_BIT0) && (state <= S_BIT7))
        txd <= tto[bit_sel];
      else
        txd <= 1'b1;
    end
  end

endmodule

//--- src/iot_decode.sv
`timescale 1ns/10ps

module iot_decode
  import tty_pkg::*;
(
  input  logic  clk100,
  input  logic  rst,
  input  logic  iot_valid,
  input  word_t iot_word,
  input  word_t ac_in,
  output logic  skip,
  output logic  ac_clear,
  output word_t ac_out,
  output logic  irq,
  tty_if.ctrl   prt,
  tty_if.ctrl   kbd
);

  iot_word_t iw;
  logic      is_iot;
  logic      kbd_sel;
  logic      prt_sel;
  logic      kie;
  logic      kbd_read;
  logic      int_en;

  assign iw      = iot_word;
  assign is_iot  = iot_valid && (iw.opcode == OP_IOT);
  assign kbd_sel = is_iot && (iw.device == DEV_KBD);
  assign prt_sel = is_iot && (iw.device == DEV_PRT);

  // KIE shares the skip and read bits, so pick it out first
  assign kie      = kbd_sel && (iw.func == FN_KIE);
  assign kbd_read = kbd_sel && !kie && iw.func[FN_LOAD];

  // printer strobes, TLS raises load and clear together
  assign prt.load       = prt_sel && iw.func[FN_LOAD];
  assign prt.clear_flag = prt_sel && iw.func[FN_CLEAR];
  assign prt.set_flag   = prt_sel && (iw.func == FN_SPF);
  assign prt.data       = ac_in[CHAR_W-1:0];

  // keyboard side only ever has its flag cleared from here
  assign kbd.load       = 1'b0;
  assign kbd.set_flag   = 1'b0;
  assign kbd.data       = ac_in[CHAR_W-1:0];
  assign kbd.clear_flag = kbd_sel && iw.func[FN_CLEAR];

  assign skip = (kbd_sel && !kie && iw.func[FN_SKIP] && kbd.flag) ||
                (prt_sel && iw.func[FN_SKIP] && prt.flag);

  // KCC and KRB clear the AC, KRS and KRB put the buffer on the bus
  assign ac_clear = kbd_sel && iw.func[FN_CLEAR];
  assign ac_out   = kbd_read ? {{(WORD_W - CHAR_W){1'b0}}, kbd.buffer} : '0;

  always_ff @(posedge clk100) begin
    if (rst) begin
      int_en <= 1'b0;
      irq    <= 1'b0;
    end else begin
      if (kie)
        int_en <= ac_in[0];
      // one request line shared by both units
      irq <= int_en && (kbd.flag || prt.flag);
    end
  end

endmodule

//--- src/tty_if.sv
`timescale 1ns/10ps

interface tty_if
  import tty_pkg::*;
();

  // strobes from the IOT decoder, one cycle wide
  logic  load;
  logic  clear_flag;
  logic  set_flag;
  char_t data;

  // status back from the serial unit
  logic  flag;
  char_t buffer;

  modport ctrl (
    output load,
    output clear_flag,
    output set_flag,
    output data,
    input  flag,
    input  buffer
  );

  modport unit (
    input  load,
    input  clear_flag,
    input  set_flag,
    input  data,
    output flag,
    output buffer
  );

endinterface

//--- src/tty_pkg.sv
package tty_pkg;

  localparam int CHAR_W = 8;
  localparam int WORD_W = 12;

  // accumulator or instruction word
  typedef logic [WORD_W-1:0] word_t;

  // teleprinter character, low eight bits of a word (char[4:11] in DEC order)
  typedef logic [CHAR_W-1:0] char_t;

  // IOT instruction layout, 6DDF in octal
  typedef struct packed {
    logic [2:0] opcode;
    logic [5:0] device;
    logic [2:0] func;
  } iot_word_t;

  localparam logic [2:0] OP_IOT = 3'o6;

  // console device codes
  localparam logic [5:0] DEV_KBD = 6'o03;
  localparam logic [5:0] DEV_PRT = 6'o04;

  // function bit positions inside iot_word_t.func
  localparam int FN_SKIP  = 0;
  localparam int FN_CLEAR = 1;
  localparam int FN_LOAD  = 2;

  // whole function codes that do not follow the bit meanings
  localparam logic [2:0] FN_SPF = 3'o0;
  localparam logic [2:0] FN_KIE = 3'o5;

endpackage
